//--- flist.f
logic/dram_geom_pkg.sv
logic/dram_cmd_pkg.sv
logic/dram_cmd_ctrl.sv
logic/dram_latency_queue.sv
logic/dram_array.sv
logic/dram_read_port.sv
logic/dram_device.sv
verif/dram_device_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= dram_device_tb
RTL_TOP ?= dram_device
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

ALL_FILES := $(shell cat $(FLIST))
RTL_FILES := $(filter logic/%,$(ALL_FILES))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) $(RTL_FILES)

$(BUILD_DIR)/V$(TOP): $(ALL_FILES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/dram_device_tb.sv
`timescale 1ns/1ns

module dram_device_tb
	import dram_geom_pkg::*;
	import dram_cmd_pkg::*;
();

	localparam dram_cmd_t nop_cmd = '1;
	localparam int test_count = 6;
	localparam int test_cycles = 300; // Longest test stays well below this
	localparam int timeout_ns = (test_count * test_cycles + 50) * 10;

	logic clk = 1'b0;
	logic arst_n;
	dram_cmd_t cmd;
	word_t wr_data;
	word_t rd_data;
	logic rd_valid;
	logic rd_strobe;

	int cyc = 0;
	int blen = 4;
	int cas = 2;
	int align = 0;
	int open_row [4] = '{0, 0, 0, 0};
	logic [15:0] lfsr = 16'd25837;
	word_t ref_mem [int];
	word_t exp_word [$];
	int exp_cycle [$];
	logic exp_strobe = 1'b0;
	string test_name = "none";
	int checks = 0;
	int errors = 0;
	int test_errs0 = 0;

	dram_device u_dram_device (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd       (cmd),
		.wr_data   (wr_data),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.rd_strobe (rd_strobe)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic word_t next_word();
		word_t w;
		w = '0;
		for (int i = 0; i < 72; i++)
		begin
			lfsr = lfsr_step(lfsr);
			w = {w[70:0], lfsr[0]};
		end
		return w;
	endfunction

	// Array index of beat n, column wraps inside its aligned group
	function automatic int beat_addr(input int ba, input int row, input int col,
			input int len, input int n);
		int base;
		base = col - (col % len);
		return row * 64 + ba * 16 + base + (col + n) % len;
	endfunction

	task automatic check_value(input string what, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic issue(input logic [3:0] code, input int ba, input int addr, output int c);
		@(negedge clk);
		cmd = {code, bank_t'(ba), bus_addr_t'(addr)};
		c = cyc;
	endtask

	task automatic set_mode(input int ba, input int addr);
		int c;
		issue(4'b0000, ba, addr, c);
		if (ba == 0)
		begin
			blen = 1 << (addr % 4);
			cas = (addr / 16) % 8;
		end
		else if (ba == 1)
			align = (addr / 8) % 8;
		@(negedge clk) cmd = nop_cmd;
	endtask

	task automatic activate(input int ba, input int row);
		int c;
		issue(4'b0011, ba, row, c);
		open_row[ba] = row % 16;
		@(negedge clk) cmd = nop_cmd;
	endtask

	task automatic write_burst(input int ba, input int col);
		int c;
		int a;
		issue(4'b0100, ba, col, c);
		for (int n = 0; n < blen; n++)
		begin
			a = beat_addr(ba, open_row[ba], col, blen, n);
			while (cyc < c + cas + align + 1 + n)
				@(negedge clk) cmd = nop_cmd;
			wr_data = next_word();
			ref_mem[a] = wr_data;
		end
		@(negedge clk) wr_data = '0;
	endtask

	task automatic read_burst(input int ba, input int col);
		int c;
		int a;
		issue(4'b0101, ba, col, c);
		for (int n = 0; n < blen; n++)
		begin
			a = beat_addr(ba, open_row[ba], col, blen, n);
			exp_word.push_back(ref_mem.exists(a) ? ref_mem[a] : '0);
			exp_cycle.push_back(c + cas + align + 3 + n);
		end
		@(negedge clk) cmd = nop_cmd;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs0 = errors;
	endtask

	task automatic drain_reads();
		while (exp_cycle.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);
	endtask

	task automatic end_test();
		drain_reads();
		$display("%s: %0d errors", test_name, errors - test_errs0);
	endtask

	task automatic wrap_case(input int code, input int wcol, input int rcol);
		set_mode(0, 32 + code);
		write_burst(1, wcol);
		read_burst(1, rcol);
		drain_reads();
	endtask

	// Scoreboard compare, outputs are stable at the falling edge
	always @(negedge clk)
	begin
		int ec;
		word_t ew;
		logic beat_due;
		if (arst_n)
		begin
			beat_due = exp_cycle.size() != 0 && exp_cycle[0] == cyc;
			if ($isunknown(rd_valid))
			begin
				errors++;
				$display("error %s: rd_valid is unknown on cycle %0d", test_name, cyc);
			end
			exp_strobe = beat_due ? ~exp_strobe : 1'b0;
			check_value("rd_strobe", word_t'(exp_strobe), word_t'(rd_strobe));
			if (rd_valid && exp_cycle.size() == 0)
			begin
				errors++;
				$display("error %s: rd_valid high on cycle %0d with no read pending",
					test_name, cyc);
			end
			else if (rd_valid || (exp_cycle.size() != 0 && cyc >= exp_cycle[0]))
			begin
				ec = exp_cycle.pop_front();
				ew = exp_word.pop_front();
				if (!rd_valid || ec != cyc)
				begin
					errors++;
					$display("error %s: read beat due on cycle %0d, rd_valid %0b on cycle %0d",
						test_name, ec, rd_valid, cyc);
				end
				if (rd_valid)
					check_value("rd_data", ew, rd_data);
			end
		end
	end

	initial
	begin
		#(timeout_ns);
		$display("timeout: run still busy after %0d ns", timeout_ns);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		cmd = nop_cmd;
		wr_data = '0;
		arst_n = 1'b0;
		for (int i = 0; i < array_words; i++)
			u_dram_device.u_array.mem[i] = '0; // Array has no reset
		repeat (4) @(posedge clk);
		@(negedge clk) arst_n = 1'b1;

		start_test("reset_idle");
		repeat (20) @(negedge clk);
		read_burst(0, 0);
		end_test();

		start_test("burst4_bank1");
		activate(1, 5);
		set_mode(0, 8'h22);
		write_burst(1, 4);
		read_burst(1, 4);
		end_test();

		start_test("wrap_order");
		wrap_case(0, 3, 3);
		wrap_case(1, 9, 8);
		wrap_case(3, 13, 10);
		end_test();

		start_test("four_banks");
		set_mode(0, 8'h22);
		for (int b = 0; b < 4; b++)
		begin
			activate(b, 2 + 3 * b);
			write_burst(b, 0);
		end
		foreach (open_row[i])
		begin
			read_burst((i * 2 + 2) % 4 + i / 2, 0); // Order 2, 0, 3, 1
			repeat (blen) @(negedge clk);
		end
		activate(0, 0); // Other row of bank 0 still holds zeros
		read_burst(0, 0);
		end_test();

		start_test("latency_change");
		set_mode(0, 8'h52);
		set_mode(1, 8'h18);
		write_burst(2, 4);
		read_burst(2, 4);
		repeat (blen) @(negedge clk);
		read_burst(0, 0);
		end_test();

		start_test("back_to_back");
		set_mode(1, 8'h00);
		set_mode(0, 8'h32);
		read_burst(3, 0);
		repeat (blen - 2) @(negedge clk);
		read_burst(0, 0);
		repeat (blen - 2) @(negedge clk);
		read_burst(1, 0);
		end_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- logic/dram_device.sv
`timescale 1ns/1ns

module dram_device
	import dram_geom_pkg::*;
	import dram_cmd_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  dram_cmd_t cmd,
	input  word_t wr_data,
	output word_t rd_data,
	output logic rd_valid,
	output logic rd_strobe
);

	logic [queue_depth-1:0] rd_ins_valid;
	logic [queue_depth-1:0] wr_ins_valid;
	beat_addr_t [queue_depth-1:0] rd_ins_addr;
	beat_addr_t [queue_depth-1:0] wr_ins_addr;

	logic rd_head_valid;
	logic wr_head_valid;
	beat_addr_t rd_head_addr;
	beat_addr_t wr_head_addr;

	logic rd_beat_valid; // Lines up with word_q
	word_t word_q;

	dram_cmd_ctrl u_cmd_ctrl (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd          (cmd),
		.rd_ins_valid (rd_ins_valid),
		.wr_ins_valid (wr_ins_valid),
		.rd_ins_addr  (rd_ins_addr),
		.wr_ins_addr  (wr_ins_addr)
	);

	dram_latency_queue u_rd_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.ins_valid  (rd_ins_valid),
		.ins_addr   (rd_ins_addr),
		.head_valid (rd_head_valid),
		.head_addr  (rd_head_addr)
	);

	dram_latency_queue u_wr_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.ins_valid  (wr_ins_valid),
		.ins_addr   (wr_ins_addr),
		.head_valid (wr_head_valid),
		.head_addr  (wr_head_addr)
	);

	dram_array u_array (
		.clk     (clk),
		.rd_en   (rd_head_valid),
		.rd_addr (rd_head_addr),
		.wr_en   (wr_head_valid),
		.wr_addr (wr_head_addr),
		.wr_data (wr_data),
		.word_q  (word_q)
	);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rd_beat_valid <= 1'b0;
		else
			rd_beat_valid <= rd_head_valid;
	end

	dram_read_port u_read_port (
		.clk        (clk),
		.arst_n     (arst_n),
		.beat_valid (rd_beat_valid),
		.word_q     (word_q),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid),
		.rd_strobe  (rd_strobe)
	);

endmodule

//--- logic/dram_read_port.sv
`timescale 1ns/1ns

module dram_read_port
	import dram_geom_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic beat_valid,
	input  word_t word_q,
	output word_t rd_data,
	output logic rd_valid,
	output logic rd_strobe
);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_valid <= 1'b0;
			rd_strobe <= 1'b0;
		end
		else
		begin
			rd_valid <= beat_valid;
			rd_strobe <= beat_valid ? ~rd_strobe : 1'b0; // Idle strobe parks low
		end
	end

	always_ff @(posedge clk)
	begin
		if (beat_valid)
			rd_data <= word_q;
	end

	assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(rd_valid))
		else $error("rd_valid unknown");

endmodule

//--- logic/dram_array.sv
`timescale 1ns/1ns

module dram_array
	import dram_geom_pkg::*;
(
	input  logic clk,
	input  logic rd_en,
	input  beat_addr_t rd_addr,
	input  logic wr_en,
	input  beat_addr_t wr_addr,
	input  word_t wr_data,
	output word_t word_q
);

	word_t mem [array_words];

	// Same word read and written returns the old contents
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			word_q <= mem[rd_addr];
	end

endmodule

//--- logic/dram_latency_queue.sv
`timescale 1ns/1ns

module dram_latency_queue
	import dram_geom_pkg::*;
	import dram_cmd_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic [queue_depth-1:0] ins_valid,
	input  beat_addr_t [queue_depth-1:0] ins_addr,
	output logic head_valid,
	output beat_addr_t head_addr
);

	// Slot contents as seen this cycle, inserts merged in
	logic [queue_depth-1:0] view_valid;
	beat_addr_t [queue_depth-1:0] view_addr;

	logic [queue_depth-2:0] slot_valid;
	beat_addr_t [queue_depth-2:0] slot_addr;

	always_comb
	begin
		for (int i = 0; i < queue_depth - 1; i++)
		begin
			view_valid[i] = ins_valid[i] | slot_valid[i];
			view_addr[i] = ins_valid[i] ? ins_addr[i] : slot_addr[i]; // Later insert wins
		end
		view_valid[queue_depth-1] = ins_valid[queue_depth-1];
		view_addr[queue_depth-1] = ins_addr[queue_depth-1];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			slot_valid <= '0;
		else
			slot_valid <= view_valid[queue_depth-1:1];
	end

	always_ff @(posedge clk)
	begin
		slot_addr <= view_addr[queue_depth-1:1];
	end

	assign head_valid = view_valid[0];
	assign head_addr = view_addr[0];

	assert property (@(posedge clk) disable iff (!arst_n)
		slot_valid[queue_depth-2] |-> ins_valid[queue_depth-1:queue_depth-2] == '0)
		else $error("insert beyond last usable slot");

endmodule

//--- logic/dram_cmd_ctrl.sv
`timescale 1ns/1ns

module dram_cmd_ctrl
	import dram_geom_pkg::*;
	import dram_cmd_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  dram_cmd_t cmd,
	output logic [queue_depth-1:0] rd_ins_valid,
	output logic [queue_depth-1:0] wr_ins_valid,
	output beat_addr_t [queue_depth-1:0] rd_ins_addr,
	output beat_addr_t [queue_depth-1:0] wr_ins_addr
);

	dram_cmd_t cmd_q;
	cmd_e cmd_dec;

	logic [1:0] burst_code;
	lat_t cas_lat;
	lat_t align_lat;
	lat_t read_lat;
	lat_t write_lat;
	row_t row_q [bank_count];

	col_t burst_mask;
	col_t base_col;
	row_t open_row;
	slot_t rd_first;
	slot_t wr_first;

	// Column walks inside an aligned group of burst length
	function automatic beat_addr_t wrap_addr(input row_t row, input bank_t ba,
			input col_t col, input col_t mask, input slot_t beat);
		beat_addr_t a;
		a.row = row;
		a.bank = ba;
		a.col = (col & ~mask) | ((col + col_t'(beat)) & mask);
		return a;
	endfunction

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cmd_q <= '1; // Deselected
		else
			cmd_q <= cmd;
	end

	always_comb
	begin
		case ({cmd_q.cs_n, cmd_q.ras_n, cmd_q.cas_n, cmd_q.we_n})
			4'b0101: cmd_dec = cmd_read;
			4'b0100: cmd_dec = cmd_write;
			4'b0011: cmd_dec = cmd_activate;
			4'b0000: cmd_dec = cmd_mode;
			default: cmd_dec = cmd_nop;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			burst_code <= burst_code_rst;
			cas_lat <= cas_lat_rst;
			align_lat <= align_lat_rst;
			for (int b = 0; b < bank_count; b++)
				row_q[b] <= '0;
		end
		else
		begin
			if (cmd_dec == cmd_activate)
				row_q[cmd_q.ba] <= cmd_q.addr[row_w-1:0];
			if (cmd_dec == cmd_mode && cmd_q.ba == bank_t'(0))
			begin
				burst_code <= cmd_q.addr[1:0];
				cas_lat <= lat_t'(cmd_q.addr[6:4]);
			end
			if (cmd_dec == cmd_mode && cmd_q.ba == bank_t'(1))
				align_lat <= lat_t'(cmd_q.addr[5:3]);
		end
	end

	assign read_lat = cas_lat + align_lat;
	assign write_lat = read_lat - lat_t'(1);

	assign burst_mask = col_t'((5'd1 << burst_code) - 5'd1);
	assign base_col = cmd_q.addr[col_w-1:0];
	assign open_row = row_q[cmd_q.ba];
	assign rd_first = slot_t'(read_lat);
	assign wr_first = slot_t'(write_lat) + slot_t'(1);

	// One slot per beat, beat n lands n slots above the first
	always_comb
	begin
		slot_t rd_beat;
		slot_t wr_beat;
		for (int s = 0; s < queue_depth; s++)
		begin
			rd_beat = slot_t'(s) - rd_first;
			wr_beat = slot_t'(s) - wr_first;
			rd_ins_valid[s] = (cmd_dec == cmd_read) && (slot_t'(s) >= rd_first) &&
				(rd_beat <= slot_t'(burst_mask));
			wr_ins_valid[s] = (cmd_dec == cmd_write) && (slot_t'(s) >= wr_first) &&
				(wr_beat <= slot_t'(burst_mask));
			rd_ins_addr[s] = wrap_addr(open_row, cmd_q.ba, base_col, burst_mask, rd_beat);
			wr_ins_addr[s] = wrap_addr(open_row, cmd_q.ba, base_col, burst_mask, wr_beat);
		end
	end

	// Mode may have been rewritten between reset and this read
	assert property (@(posedge clk) disable iff (!arst_n)
		cmd_dec == cmd_read |-> cas_lat >= cas_lat_min)
		else $error("read decoded with CAS latency %0d", cas_lat);

	// Each read or write marks one slot per beat
	assert property (@(posedge clk) disable iff (!arst_n)
		cmd_dec inside {cmd_read, cmd_write} |->
			$countones(rd_ins_valid | wr_ins_valid) == (32'd1 << burst_code))
		else $error("burst scheduled with wrong beat count");

endmodule

//--- logic/dram_cmd_pkg.sv
package dram_cmd_pkg;

	import dram_geom_pkg::*;

	typedef logic [7:0] bus_addr_t;

	// Sampled one clock after the bus drives it
	typedef struct packed {
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		bank_t ba;
		bus_addr_t addr;
	} dram_cmd_t;

	typedef enum logic [2:0] {
		cmd_nop,
		cmd_read,
		cmd_write,
		cmd_activate,
		cmd_mode
	} cmd_e;

	typedef logic [3:0] lat_t;

	localparam int queue_depth = 32;
	typedef logic [$clog2(queue_depth)-1:0] slot_t;

	localparam lat_t cas_lat_min = 4'd2;

	// Mode after reset, burst code 2 gives four beats
	localparam logic [1:0] burst_code_rst = 2'd2;
	localparam lat_t cas_lat_rst = 4'd2;
	localparam lat_t align_lat_rst = 4'd0;

endpackage

//--- logic/dram_geom_pkg.sv
package dram_geom_pkg;

	localparam int bank_w = 2;
	localparam int row_w = 4;
	localparam int col_w = 4;
	localparam int data_w = 64;
	localparam int ecc_w = 8;

	localparam int bank_count = 2 ** bank_w;
	localparam int array_words = 1024;

	typedef logic [bank_w-1:0] bank_t;
	typedef logic [row_w-1:0] row_t;
	typedef logic [col_w-1:0] col_t;

	// ECC byte sits above the data
	typedef logic [data_w+ecc_w-1:0] word_t;

	// Also the array index, row in the top bits
	typedef struct packed {
		row_t row;
		bank_t bank;
		col_t col;
	} beat_addr_t;

endpackage
